// ==== src/cpuPkg.sv ====
package cpuPkg;

    localparam int regCount = 32;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    //////////////////////////////
    // Instruction fields

    typedef enum logic [5:0] {
        opRtype = 6'd0,
        opJ     = 6'd2,
        opJal   = 6'd3,
        opBeq   = 6'd4,
        opBne   = 6'd5,
        opAddi  = 6'd8,
        opAddiu = 6'd9,
        opSlti  = 6'd10,
        opAndi  = 6'd12,
        opOri   = 6'd13,
        opXori  = 6'd14,
        opLw    = 6'd35,
        opSw    = 6'd43,
        opBgt   = 6'd48,   // Extended branches, moved clear of lw
        opBge   = 6'd49,
        opBlt   = 6'd50,
        opBle   = 6'd51,
        opBleu  = 6'd52,
        opBgtu  = 6'd53,
        opSeqi  = 6'd54
    } opcodeT;

    typedef enum logic [5:0] {
        fnSll  = 6'd0,
        fnSrl  = 6'd2,
        fnSra  = 6'd3,
        fnJr   = 6'd8,
        fnAdd  = 6'd32,
        fnAddu = 6'd33,
        fnSub  = 6'd34,
        fnSubu = 6'd35,
        fnAnd  = 6'd36,
        fnOr   = 6'd37,
        fnXor  = 6'd38,
        fnSlt  = 6'd42,
        fnSeq  = 6'd48
    } functT;

    //////////////////////////////
    // Decode results

    // Main decoder to ALU decoder
    typedef enum logic [2:0] {
        reqRtype, reqAdd, reqAddu, reqAnd, reqOr, reqXor, reqSlt, reqSeq
    } aluReqT;

    typedef enum logic [3:0] {
        aluAdd, aluAddu, aluSub, aluSubu, aluAnd, aluOr,
        aluXor, aluSlt, aluSeq, aluSll, aluSrl, aluSra
    } aluOpT;

    typedef enum logic [3:0] {
        brNone, brEq, brNe, brGt, brGe, brLt, brLe, brLeu, brGtu
    } branchCondT;

    typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;
    typedef enum logic [1:0] {dstRt, dstRd, dstRa} dstSelT;

endpackage

// ==== src/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit import cpuPkg::*; (
    input  opcodeT     opcode,
    output dstSelT     dstSel,
    output wbSelT      wbSel,
    output logic       regWrite,
    output logic       aluSrcImm,
    output logic       memWrite,
    output logic       jump,
    output branchCondT branchCond,
    output aluReqT     aluReq
);

    always_comb begin
        // Everything idle, so an unknown opcode just steps to PC+1
        dstSel     = dstRt;
        wbSel      = wbAlu;
        regWrite   = 1'b0;
        aluSrcImm  = 1'b0;
        memWrite   = 1'b0;
        jump       = 1'b0;
        branchCond = brNone;
        aluReq     = reqAdd;

        case (opcode)
            opRtype: begin
                dstSel   = dstRd;   // jr lands on r0 and is dropped
                regWrite = 1'b1;
                aluReq   = reqRtype;
            end
            opAddi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
            end
            opAddiu: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluReq    = reqAddu;
            end
            opAndi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluReq    = reqAnd;
            end
            opOri: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluReq    = reqOr;
            end
            opXori: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluReq    = reqXor;
            end
            opSlti: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluReq    = reqSlt;
            end
            opSeqi: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluReq    = reqSeq;
            end
            opLw: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;   // Address is rs + imm
                wbSel     = wbMem;
            end
            opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            opBeq:  branchCond = brEq;
            opBne:  branchCond = brNe;
            opBgt:  branchCond = brGt;
            opBge:  branchCond = brGe;
            opBlt:  branchCond = brLt;
            opBle:  branchCond = brLe;
            opBleu: branchCond = brLeu;
            opBgtu: branchCond = brGtu;
            opJ:    jump = 1'b1;
            opJal: begin
                jump     = 1'b1;
                regWrite = 1'b1;
                dstSel   = dstRa;
                wbSel    = wbLink;
            end
            default: ;
        endcase
    end

endmodule

// ==== src/aluDecoder.sv ====
`timescale 1ns/1ns

module aluDecoder import cpuPkg::*; (
    input  aluReqT aluReq,
    input  functT  funct,
    output aluOpT  aluOp,
    output logic   jumpReg
);

    always_comb begin
        aluOp   = aluAdd;
        jumpReg = 1'b0;

        case (aluReq)
            reqRtype: begin
                case (funct)
                    fnAdd:   aluOp = aluAdd;
                    fnAddu:  aluOp = aluAddu;
                    fnSub:   aluOp = aluSub;
                    fnSubu:  aluOp = aluSubu;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnXor:   aluOp = aluXor;
                    fnSlt:   aluOp = aluSlt;
                    fnSeq:   aluOp = aluSeq;
                    fnSll:   aluOp = aluSll;
                    fnSrl:   aluOp = aluSrl;
                    fnSra:   aluOp = aluSra;
                    fnJr:    jumpReg = 1'b1;   // Result unused
                    default: aluOp = aluAdd;
                endcase
            end
            reqAddu: aluOp = aluAddu;
            reqAnd:  aluOp = aluAnd;
            reqOr:   aluOp = aluOr;
            reqXor:  aluOp = aluXor;
            reqSlt:  aluOp = aluSlt;
            reqSeq:  aluOp = aluSeq;
            default: aluOp = aluAdd;   // addi, lw, sw
        endcase
    end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu import cpuPkg::*; (
    input  wordT       opA,
    input  wordT       opB,
    input  logic [4:0] shamt,
    input  aluOpT      aluOp,
    input  branchCondT branchCond,
    output wordT       result,
    output logic       branchTaken
);

    always_comb begin
        case (aluOp)
            aluAdd, aluAddu: result = opA + opB;   // No overflow trap either way
            aluSub, aluSubu: result = opA - opB;
            aluAnd:          result = opA & opB;
            aluOr:           result = opA | opB;
            aluXor:          result = opA ^ opB;
            aluSlt:          result = wordT'($signed(opA) < $signed(opB));
            aluSeq:          result = wordT'(opA == opB);
            aluSll:          result = opB << shamt;
            aluSrl:          result = opB >> shamt;
            aluSra:          result = wordT'($signed(opB) >>> shamt);
            default:         result = '0;
        endcase
    end

    // Branch comparator, rs against rt
    always_comb begin
        case (branchCond)
            brEq:    branchTaken = (opA == opB);
            brNe:    branchTaken = (opA != opB);
            brGt:    branchTaken = ($signed(opA) > $signed(opB));
            brGe:    branchTaken = ($signed(opA) >= $signed(opB));
            brLt:    branchTaken = ($signed(opA) < $signed(opB));
            brLe:    branchTaken = ($signed(opA) <= $signed(opB));
            brLeu:   branchTaken = (opA <= opB);
            brGtu:   branchTaken = (opA > opB);
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    we,
    input  regAddrT rdAddrA,
    input  regAddrT rdAddrB,
    input  regAddrT wrAddr,
    input  wordT    wrData,
    output wordT    rdDataA,
    output wordT    rdDataB
);

    wordT regs [regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wrAddr != '0) begin   // r0 stays zero
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

// ==== src/wordMemory.sv ====
`timescale 1ns/1ns

module wordMemory import cpuPkg::*; #(
    parameter int addrBits = 10
) (
    input  logic                clk,
    input  logic                we,
    input  logic [addrBits-1:0] wrAddr,
    input  wordT                wrData,
    input  logic [addrBits-1:0] rdAddrA,
    input  logic [addrBits-1:0] rdAddrB,
    output wordT                rdDataA,
    output wordT                rdDataB
);

    wordT mem [2**addrBits];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Asynchronous reads, same cycle as the address
    assign rdDataA = mem[rdAddrA];
    assign rdDataB = mem[rdAddrB];

endmodule

// ==== src/pcUnit.sv ====
`timescale 1ns/1ns

module pcUnit import cpuPkg::*; #(
    parameter int pcBits = 10
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold,
    input  logic        jump,
    input  logic        jumpReg,
    input  logic        branchTaken,
    input  logic [25:0] jumpIndex,
    input  wordT        branchOffset,
    input  wordT        regTarget,
    output wordT        pc,
    output wordT        pcPlusOne
);

    logic [pcBits-1:0] pcReg;   // Word address, only as wide as imem
    wordT              nextPc;

    assign pc        = wordT'(pcReg);
    assign pcPlusOne = pc + 32'd1;

    always_comb begin
        if (jumpReg) begin
            nextPc = regTarget;
        end else if (jump) begin
            nextPc = {pcPlusOne[31:28], 2'b00, jumpIndex};   // Bits 27:26 forced low
        end else if (branchTaken) begin
            nextPc = pcPlusOne + branchOffset;
        end else begin
            nextPc = pcPlusOne;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= '0;
        end else if (!hold) begin
            pcReg <= nextPc[pcBits-1:0];
        end
    end

endmodule

// ==== src/cpuCore.sv ====
`timescale 1ns/1ns

module cpuCore import cpuPkg::*; #(
    parameter int imemAddrBits = 10,
    parameter int dmemAddrBits = 10
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load,
    input  logic                    imemLoadWe,
    input  logic [imemAddrBits-1:0] imemLoadAddr,
    input  wordT                    imemLoadData,
    input  logic                    dmemLoadWe,
    input  logic [dmemAddrBits-1:0] dmemLoadAddr,
    input  wordT                    dmemLoadData,
    input  logic [dmemAddrBits-1:0] dmemPeekAddr,
    output wordT                    dmemPeekData,
    output wordT                    pc
);

    wordT       instr, rsData, rtData, immExt, opB, aluResult, memData, wbData, pcPlusOne;
    opcodeT     opcode;
    functT      funct;
    regAddrT    rs, rt, rd, wrReg;
    logic [4:0] shamt;
    dstSelT     dstSel;
    wbSelT      wbSel;
    logic       regWrite, aluSrcImm, memWrite, jump, jumpReg, branchTaken;
    branchCondT branchCond;
    aluReqT     aluReq;
    aluOpT      aluOp;

    logic                    dmemWe;
    logic [dmemAddrBits-1:0] dmemWrAddr;
    wordT                    dmemWrData;

    //////////////////////////////
    // Fetch and field split

    wordMemory #(.addrBits(imemAddrBits)) imem (
        .clk(clk), .we(load & imemLoadWe), .wrAddr(imemLoadAddr), .wrData(imemLoadData),
        .rdAddrA(pc[imemAddrBits-1:0]), .rdAddrB('0),
        .rdDataA(instr), .rdDataB()
    );

    assign opcode = opcodeT'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = functT'(instr[5:0]);
    assign immExt = {{16{instr[15]}}, instr[15:0]};   // Every immediate is signed

    //////////////////////////////
    // Decode and execute

    controlUnit ctrl (
        .opcode(opcode), .dstSel(dstSel), .wbSel(wbSel), .regWrite(regWrite),
        .aluSrcImm(aluSrcImm), .memWrite(memWrite), .jump(jump),
        .branchCond(branchCond), .aluReq(aluReq)
    );

    aluDecoder aluDec (.aluReq(aluReq), .funct(funct), .aluOp(aluOp), .jumpReg(jumpReg));

    regFile regs (
        .clk(clk), .rst(rst), .we(regWrite & ~load),
        .rdAddrA(rs), .rdAddrB(rt), .wrAddr(wrReg), .wrData(wbData),
        .rdDataA(rsData), .rdDataB(rtData)
    );

    assign opB = aluSrcImm ? immExt : rtData;

    alu aluUnit (
        .opA(rsData), .opB(opB), .shamt(shamt), .aluOp(aluOp),
        .branchCond(branchCond), .result(aluResult), .branchTaken(branchTaken)
    );

    //////////////////////////////
    // Memory and writeback

    // Loader owns the write port while load is high
    assign dmemWe     = load ? dmemLoadWe   : memWrite;
    assign dmemWrAddr = load ? dmemLoadAddr : aluResult[dmemAddrBits-1:0];
    assign dmemWrData = load ? dmemLoadData : rtData;

    wordMemory #(.addrBits(dmemAddrBits)) dmem (
        .clk(clk), .we(dmemWe), .wrAddr(dmemWrAddr), .wrData(dmemWrData),
        .rdAddrA(aluResult[dmemAddrBits-1:0]), .rdAddrB(dmemPeekAddr),
        .rdDataA(memData), .rdDataB(dmemPeekData)
    );

    always_comb begin
        case (dstSel)
            dstRd:   wrReg = rd;
            dstRa:   wrReg = regAddrT'(regCount - 1);   // Link register r31
            default: wrReg = rt;
        endcase
        case (wbSel)
            wbMem:   wbData = memData;
            wbLink:  wbData = pcPlusOne;
            default: wbData = aluResult;
        endcase
    end

    pcUnit #(.pcBits(imemAddrBits)) pcu (
        .clk(clk), .rst(rst), .hold(load), .jump(jump), .jumpReg(jumpReg),
        .branchTaken(branchTaken), .jumpIndex(instr[25:0]), .branchOffset(immExt),
        .regTarget(rsData), .pc(pc), .pcPlusOne(pcPlusOne)
    );

endmodule

// ==== include/cpuPrograms.svh ====
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

localparam int caseCount     = 6;
localparam int progWordCount = 109;
localparam int preloadCount  = 4;
localparam int checkCount    = 31;

// Case c owns entries start[c] up to start[c+1]-1
// Every program loads from imem address 0
localparam int progStart [caseCount+1]    = '{0, 25, 46, 57, 95, 105, 109};
localparam int progHalt [caseCount]       = '{24, 20, 10, 37, 5, 3};
localparam int preloadStart [caseCount+1] = '{0, 0, 0, 2, 2, 3, 4};
localparam int checkStart [caseCount+1]   = '{0, 11, 20, 23, 25, 28, 31};

localparam logic [31:0] progWords [progWordCount] = '{
    // 1) ALU ops on -5 and 12 with results stored at 16..26
    32'h2001FFFB, 32'h2002000C, 32'h00221820, 32'h00222022,
    32'h00222821, 32'h00413023, 32'h00223824, 32'h00224025,
    32'h00224826, 32'h302A00F0, 32'h344BFF00, 32'h382CFFFF,
    32'hD82DFFFB, 32'hAC030010, 32'hAC040011, 32'hAC050012,
    32'hAC060013, 32'hAC070014, 32'hAC080015, 32'hAC090016,
    32'hAC0A0017, 32'hAC0B0018, 32'hAC0C0019, 32'hAC0D001A,
    32'h08000018,
    // 2) Shifts of -16 and slt/slti/seq with results stored at 32..40
    32'h2001FFF0, 32'h20020003, 32'h00011900, 32'h00012102,
    32'h00012903, 32'h0022302A, 32'h0041382A, 32'h2828FFEC,
    32'h28490004, 32'h00215030, 32'h00225830, 32'hAC030020,
    32'hAC040021, 32'hAC050022, 32'hAC060023, 32'hAC070024,
    32'hAC080025, 32'hAC090026, 32'hAC0A0027, 32'hAC0B0028,
    32'h08000014,
    // 3) lw with offset and add into a sw to 50 before r0 writes stored to 51 and 52
    32'h20010005, 32'h8C220003, 32'h8C230004, 32'h00432020,
    32'hAC24002D, 32'h2000004D, 32'h8C200003, 32'hAC20002E,
    32'h00420020, 32'hAC20002F, 32'h0800000A,
    // 4) Taken branches skip an ori into r10 while not-taken ones fall into an ori on r11
    32'h2001FFFF, 32'h20020001, 32'h20030001, 32'h10430001,
    32'h354A0001, 32'h14220001, 32'h354A0002, 32'hC0410001,
    32'h354A0004, 32'hC4430001, 32'h354A0008, 32'hC8220001,
    32'h354A0010, 32'hCC430001, 32'h354A0020, 32'hD0410001,
    32'h354A0040, 32'hD4220001, 32'h354A0080, 32'h10220001,
    32'h356B0001, 32'h14430001, 32'h356B0002, 32'hC0220001,
    32'h356B0004, 32'hC4220001, 32'h356B0008, 32'hC8410001,
    32'h356B0010, 32'hCC410001, 32'h356B0020, 32'hD0220001,
    32'h356B0040, 32'hD4410001, 32'h356B0080, 32'hAC0A003C,
    32'hAC0B003D, 32'h08000025,
    // 5) j over a store then jal to 7 which stores r31 and jr back to 4
    32'h20010011, 32'h08000003, 32'hAC010046, 32'h0C000007,
    32'hAC020048, 32'h08000005, 32'h00000000, 32'hAC1F0047,
    32'h20020022, 32'h03E00008,
    // 6) Reload over case 5 with lw/addi/sw to 81
    32'h8C010050, 32'h20210001, 32'hAC010051, 32'h08000003
};

// Data memory preloads as address and word pairs
localparam logic [31:0] preloadList [preloadCount][2] = '{
    '{8, 32'h00001234}, '{9, 32'hFFFFFFF0}, '{70, 32'h0000AAAA},
    '{80, 32'h00000100}
};

// Expected data memory as address and word pairs
localparam logic [31:0] checkList [checkCount][2] = '{
    '{16, 32'h00000007}, '{17, 32'hFFFFFFEF}, '{18, 32'h00000007},
    '{19, 32'h00000011}, '{20, 32'h00000008}, '{21, 32'hFFFFFFFF},
    '{22, 32'hFFFFFFF7}, '{23, 32'h000000F0}, '{24, 32'hFFFFFF0C},
    '{25, 32'h00000004}, '{26, 32'h00000001},
    '{32, 32'hFFFFFF00}, '{33, 32'h0FFFFFFF}, '{34, 32'hFFFFFFFF},
    '{35, 32'h00000001}, '{36, 32'h00000000}, '{37, 32'h00000000},
    '{38, 32'h00000001}, '{39, 32'h00000001}, '{40, 32'h00000000},
    '{50, 32'h00001224}, '{51, 32'h00000000}, '{52, 32'h00000000},
    '{60, 32'h00000000}, '{61, 32'h000000FF},
    '{70, 32'h0000AAAA}, '{71, 32'h00000004}, '{72, 32'h00000022},
    '{81, 32'h00000101}, '{71, 32'h00000004}, '{72, 32'h00000022}   // Case 5 words survive
};

`endif

// ==== verif/cpuCoreTb.sv ====
`timescale 1ns/1ns

module cpuCoreTb import cpuPkg::*; ();

    localparam int imemBits    = 10;
    localparam int dmemBits    = 10;
    localparam int haltTimeout = 200;   // Cycles allowed per program

    `include "cpuPrograms.svh"

    logic                clk;
    logic                rst;
    logic                load;
    logic                imemLoadWe;
    logic                dmemLoadWe;
    logic [imemBits-1:0] imemLoadAddr;
    logic [dmemBits-1:0] dmemLoadAddr;
    logic [dmemBits-1:0] dmemPeekAddr;
    wordT                imemLoadData;
    wordT                dmemLoadData;
    wordT                dmemPeekData;
    wordT                pc;

    cpuCore #(.imemAddrBits(imemBits), .dmemAddrBits(dmemBits)) UUT (
        .clk(clk), .rst(rst), .load(load),
        .imemLoadWe(imemLoadWe), .imemLoadAddr(imemLoadAddr), .imemLoadData(imemLoadData),
        .dmemLoadWe(dmemLoadWe), .dmemLoadAddr(dmemLoadAddr), .dmemLoadData(dmemLoadData),
        .dmemPeekAddr(dmemPeekAddr), .dmemPeekData(dmemPeekData), .pc(pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Program handling

    // Load stays high through reset so the old imem contents never execute
    task automatic resetAndLoad(input int c);
        @(posedge clk);
        rst        <= 1'b1;
        load       <= 1'b1;
        imemLoadWe <= 1'b0;
        dmemLoadWe <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = progStart[c]; i < progStart[c+1]; i++) begin
            imemLoadWe   <= 1'b1;
            imemLoadAddr <= imemBits'(i - progStart[c]);   // Every program starts at 0
            imemLoadData <= progWords[i];
            @(posedge clk);
        end
        imemLoadWe <= 1'b0;
        for (int p = preloadStart[c]; p < preloadStart[c+1]; p++) begin
            dmemLoadWe   <= 1'b1;
            dmemLoadAddr <= dmemBits'(preloadList[p][0]);
            dmemLoadData <= preloadList[p][1];
            @(posedge clk);
        end
        dmemLoadWe <= 1'b0;
        load       <= 1'b0;
    endtask

    task automatic runToHalt(input int c);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (pc !== wordT'(progHalt[c]) && cycles < haltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        assert (pc === wordT'(progHalt[c])) else begin
            $display("Case %0d never reached its halt address %0d within %0d cycles, pc is %0d",
                     c + 1, progHalt[c], haltTimeout, pc);
            $display("Simulation finished: FAIL");
            $fatal(1, "Program did not halt");
        end
    endtask

    // Expected words read back through the peek port
    task automatic checkMemory(input int c);
        for (int k = checkStart[c]; k < checkStart[c+1]; k++) begin
            @(posedge clk);
            dmemPeekAddr <= dmemBits'(checkList[k][0]);
            @(negedge clk);   // Peek data settled by now
            assert (dmemPeekData === checkList[k][1]) else begin
                $display("FAIL at %0t ns: case %0d, dmem[%0d] is %h, expected %h",
                         $time, c + 1, checkList[k][0], dmemPeekData, checkList[k][1]);
                $display("Simulation finished: FAIL");
                $fatal(1, "Data memory mismatch");
            end
        end
    endtask

    //////////////////////////////
    // Main sequence

    initial begin
        rst          = 1'b1;
        load         = 1'b1;
        imemLoadWe   = 1'b0;
        dmemLoadWe   = 1'b0;
        imemLoadAddr = '0;
        dmemLoadAddr = '0;
        imemLoadData = '0;
        dmemLoadData = '0;
        dmemPeekAddr = '0;

        for (int c = 0; c < caseCount; c++) begin
            resetAndLoad(c);
            runToHalt(c);
            checkMemory(c);
            $display("Case %0d done at %0t ns", c + 1, $time);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
src/cpuPkg.sv
src/controlUnit.sv
src/aluDecoder.sv
src/alu.sv
src/regFile.sv
src/wordMemory.sv
src/pcUnit.sv
src/cpuCore.sv
verif/cpuCoreTb.sv
